/* rtl/dvi_cfg.svh */
// DVI output configuration
`ifndef DVI_CFG_SVH
`define DVI_CFG_SVH

`define DVI_CLK_RATE_MHZ 25
`define DVI_I2C_QUARTER  188          // About 30 us per SCL bit at 25 MHz
`define DVI_DEV_ADDR     7'h76

// Mode 0 is 640x480
`define DVI_H_ACTIVE_0 640
`define DVI_H_FRONT_0  16
`define DVI_H_SYNC_0   96
`define DVI_H_TOTAL_0  800
`define DVI_V_ACTIVE_0 480
`define DVI_V_FRONT_0  10
`define DVI_V_SYNC_0   2
`define DVI_V_TOTAL_0  525

// Mode 1 is 1024x768
`define DVI_H_ACTIVE_1 1024
`define DVI_H_FRONT_1  24
`define DVI_H_SYNC_1   136
`define DVI_H_TOTAL_1  1344
`define DVI_V_ACTIVE_1 768
`define DVI_V_FRONT_1  3
`define DVI_V_SYNC_1   6
`define DVI_V_TOTAL_1  806

`define DVI_REG_CTRL   4'h0
`define DVI_REG_STATUS 4'h4

`endif

/* rtl/dvi_pkg.sv */
// DVI output shared types

package dvi_pkg;

  typedef logic [7:0]  i2c_byte_t;
  typedef logic [10:0] pix_count_t;
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // I2C sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_clk_fall,
    st_setup,
    st_clk_rise,
    st_stop,
    st_gap
  } i2c_state_t;

endpackage

/* rtl/dvi_apb_regs.sv */
// APB control and status registers
`timescale 1ns/1ps
`include "dvi_cfg.svh"

module dvi_apb_regs (
  input  logic               clk,
  input  logic               reset,
  input  dvi_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  dvi_pkg::apb_data_t pwdata,
  input  logic               done,
  input  logic               busy,
  input  logic               ack_error,
  output dvi_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               mode,
  output logic               restart
);

  import dvi_pkg::*;

  logic      ctrl_wr;
  logic      init_req;
  apb_data_t status_word;

  assign pready  = 1'b1;                         // No wait states
  assign ctrl_wr = psel && penable && pwrite && (paddr == `DVI_REG_CTRL);

  assign status_word = {29'd0, ack_error, busy, done};

  always_comb begin
    case (paddr)
      `DVI_REG_CTRL:   prdata = {31'd0, mode};   // Start bit reads as 0
      `DVI_REG_STATUS: prdata = status_word;
      default:         prdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mode     <= 1'b0;
      restart  <= 1'b0;
      init_req <= 1'b1;
    end else begin
      init_req <= 1'b0;
      restart  <= init_req || (ctrl_wr && pwdata[1]);  // First pulse follows reset release
      if (ctrl_wr)
        mode <= pwdata[0];
    end
  end

endmodule

/* rtl/dvi_i2c_init.sv */
// I2C register write sequencer
`timescale 1ns/1ps
`include "dvi_cfg.svh"

module dvi_i2c_init (
  input  logic clk,
  input  logic reset,
  input  logic restart,
  input  logic high_rate,
  input  logic sda_in,
  output logic scl_low,
  output logic sda_low,
  output logic done,
  output logic busy,
  output logic ack_error
);

  import dvi_pkg::*;

  localparam int quarter = `DVI_I2C_QUARTER;

  i2c_state_t  state;
  logic [9:0]  q_cnt;
  logic [9:0]  q_last;
  logic        q_end;
  logic [4:0]  bit_cnt;
  logic [2:0]  write_idx;
  logic [26:0] sreg;
  logic        ack_slot;

  // Address byte, register and data with a released ack slot after each
  function automatic logic [26:0] frame(input logic [2:0] idx, input logic rate);
    i2c_byte_t addr_byte;
    i2c_byte_t reg_addr;
    i2c_byte_t reg_data;
    addr_byte = {`DVI_DEV_ADDR, 1'b0};
    case (idx)
      3'd0: begin
        reg_addr = 8'h49;
        reg_data = 8'hC0;
      end
      3'd1: begin
        reg_addr = 8'h21;
        reg_data = 8'h09;
      end
      3'd2: begin
        reg_addr = 8'h33;
        reg_data = rate ? 8'h06 : 8'h08;
      end
      3'd3: begin
        reg_addr = 8'h34;
        reg_data = rate ? 8'h26 : 8'h16;
      end
      default: begin
        reg_addr = 8'h36;
        reg_data = rate ? 8'hA0 : 8'h60;
      end
    endcase
    return {addr_byte, 1'b1, reg_addr, 1'b1, reg_data, 1'b1};
  endfunction

  always_comb begin
    case (state)
      st_start, st_clk_fall, st_setup: q_last = 10'(quarter - 1);
      st_clk_rise:                     q_last = 10'(2 * quarter - 1);
      st_stop:                         q_last = 10'(3 * quarter - 1);
      st_gap:                          q_last = 10'(4 * quarter - 1);
      default:                         q_last = 10'd0;
    endcase
  end

  assign q_end    = (q_cnt == q_last);
  assign ack_slot = (bit_cnt == 5'd8) || (bit_cnt == 5'd17) || (bit_cnt == 5'd26);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      q_cnt     <= '0;
      bit_cnt   <= '0;
      write_idx <= '0;
      scl_low   <= 1'b0;
      sda_low   <= 1'b0;
      done      <= 1'b0;
      busy      <= 1'b1;                         // Configuration pending until first restart
      ack_error <= 1'b0;
    end else if (restart) begin
      done      <= 1'b0;
      busy      <= 1'b1;
      ack_error <= 1'b0;
      bit_cnt   <= '0;
      write_idx <= '0;
      scl_low   <= 1'b0;
      if (state == st_idle) begin
        state   <= st_start;
        q_cnt   <= '0;
        sda_low <= 1'b1;                         // Start condition right away
      end else begin
        state   <= st_gap;
        q_cnt   <= 10'(3 * quarter);             // Lines released for one quarter
        sda_low <= 1'b0;
      end
    end else begin
      q_cnt <= q_end ? '0 : q_cnt + 10'd1;
      case (state)
        st_start: begin
          if (q_end) begin
            state   <= st_clk_fall;
            scl_low <= 1'b1;
          end
        end
        st_clk_fall: begin
          if (q_end) begin
            state   <= st_setup;
            sda_low <= ~sreg[26];
          end
        end
        st_setup: begin
          if (q_end) begin
            state   <= st_clk_rise;
            scl_low <= 1'b0;
          end
        end
        st_clk_rise: begin
          if (q_cnt == 10'(quarter - 1) && ack_slot && sda_in)
            ack_error <= 1'b1;                   // Sticky while the sequence carries on
          if (q_end) begin
            scl_low <= 1'b1;
            if (bit_cnt == 5'd26) begin
              bit_cnt <= '0;
              state   <= st_stop;
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
              state   <= st_clk_fall;
            end
          end
        end
        st_stop: begin
          if (q_cnt == 10'(quarter - 1))
            sda_low <= 1'b1;
          if (q_cnt == 10'(2 * quarter - 1))
            scl_low <= 1'b0;
          if (q_end) begin
            sda_low <= 1'b0;                     // SDA rises with SCL high
            if (write_idx == 3'd4) begin
              state <= st_idle;
              busy  <= 1'b0;
              done  <= 1'b1;
            end else begin
              write_idx <= write_idx + 3'd1;
              state     <= st_gap;
            end
          end
        end
        st_gap: begin
          if (q_end) begin
            state   <= st_start;
            sda_low <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (restart)
      sreg <= frame(3'd0, high_rate);
    else if (state == st_gap && q_end)
      sreg <= frame(write_idx, high_rate);
    else if (state == st_clk_rise && q_end)
      sreg <= {sreg[25:0], 1'b0};
  end

endmodule

/* rtl/dvi_timing.sv */
// Video sync and data enable generator
`timescale 1ns/1ps
`include "dvi_cfg.svh"

module dvi_timing (
  input  logic clk,
  input  logic reset,
  input  logic restart,
  input  logic mode,
  output logic hsync,
  output logic vsync,
  output logic de
);

  import dvi_pkg::*;

  pix_count_t h_cnt;
  pix_count_t v_cnt;
  pix_count_t h_active;
  pix_count_t h_sync_start;
  pix_count_t h_sync_end;
  pix_count_t h_total;
  pix_count_t v_active;
  pix_count_t v_sync_start;
  pix_count_t v_sync_end;
  pix_count_t v_total;

  always_comb begin
    if (mode) begin
      h_active     = pix_count_t'(`DVI_H_ACTIVE_1);
      h_sync_start = pix_count_t'(`DVI_H_ACTIVE_1 + `DVI_H_FRONT_1);
      h_sync_end   = pix_count_t'(`DVI_H_ACTIVE_1 + `DVI_H_FRONT_1 + `DVI_H_SYNC_1);
      h_total      = pix_count_t'(`DVI_H_TOTAL_1);
      v_active     = pix_count_t'(`DVI_V_ACTIVE_1);
      v_sync_start = pix_count_t'(`DVI_V_ACTIVE_1 + `DVI_V_FRONT_1);
      v_sync_end   = pix_count_t'(`DVI_V_ACTIVE_1 + `DVI_V_FRONT_1 + `DVI_V_SYNC_1);
      v_total      = pix_count_t'(`DVI_V_TOTAL_1);
    end else begin
      h_active     = pix_count_t'(`DVI_H_ACTIVE_0);
      h_sync_start = pix_count_t'(`DVI_H_ACTIVE_0 + `DVI_H_FRONT_0);
      h_sync_end   = pix_count_t'(`DVI_H_ACTIVE_0 + `DVI_H_FRONT_0 + `DVI_H_SYNC_0);
      h_total      = pix_count_t'(`DVI_H_TOTAL_0);
      v_active     = pix_count_t'(`DVI_V_ACTIVE_0);
      v_sync_start = pix_count_t'(`DVI_V_ACTIVE_0 + `DVI_V_FRONT_0);
      v_sync_end   = pix_count_t'(`DVI_V_ACTIVE_0 + `DVI_V_FRONT_0 + `DVI_V_SYNC_0);
      v_total      = pix_count_t'(`DVI_V_TOTAL_0);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt >= h_total - 11'd1) begin   // Also catches a mode switch mid-line
      h_cnt <= '0;
      v_cnt <= (v_cnt >= v_total - 11'd1) ? '0 : v_cnt + 11'd1;
    end else begin
      h_cnt <= h_cnt + 11'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      de    <= 1'b0;
    end else begin
      hsync <= (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
      vsync <= (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);
      de    <= (h_cnt < h_active) && (v_cnt < v_active);
    end
  end

endmodule

/* rtl/dvi_out_top.sv */
// DVI output configuration and sync top
`timescale 1ns/1ps

module dvi_out_top (
  input  logic               clk,
  input  logic               reset,
  input  dvi_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  dvi_pkg::apb_data_t pwdata,
  input  logic               scl_in,
  input  logic               sda_in,
  output dvi_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               scl_low,
  output logic               sda_low,
  output logic               hsync,
  output logic               vsync,
  output logic               de
);

  logic mode;
  logic restart;
  logic done;
  logic busy;
  logic ack_error;

  dvi_apb_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .done      (done),
    .busy      (busy),
    .ack_error (ack_error),
    .prdata    (prdata),
    .pready    (pready),
    .mode      (mode),
    .restart   (restart)
  );

  dvi_i2c_init u_i2c (
    .clk       (clk),
    .reset     (reset),
    .restart   (restart),
    .high_rate (mode),                           // 1024x768 runs above 65 MHz
    .sda_in    (sda_in),
    .scl_low   (scl_low),
    .sda_low   (sda_low),
    .done      (done),
    .busy      (busy),
    .ack_error (ack_error)
  );

  dvi_timing u_timing (
    .clk     (clk),
    .reset   (reset),
    .restart (restart),
    .mode    (mode),
    .hsync   (hsync),
    .vsync   (vsync),
    .de      (de)
  );

endmodule

/* test/tb_i2c_slave.sv */
// I2C slave bus model
`timescale 1ns/1ps

module tb_i2c_slave (
  input  logic       clk,
  input  logic       reset,
  input  logic       abort,
  input  logic       nack,
  input  logic       scl,
  input  logic       sda,
  output logic       sda_pull,
  output logic       write_valid,
  output logic [7:0] addr_byte,
  output logic [7:0] reg_addr,
  output logic [7:0] reg_data
);

  logic        scl_q;
  logic        sda_q;
  logic        in_frame;
  logic [4:0]  bit_cnt;
  logic [26:0] shift_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      in_frame    <= 1'b0;
      bit_cnt     <= '0;
      shift_reg   <= '0;
      sda_pull    <= 1'b0;
      write_valid <= 1'b0;
    end else if (abort) begin
      scl_q       <= scl;                        // Master restart drops the frame
      sda_q       <= sda;
      in_frame    <= 1'b0;
      sda_pull    <= 1'b0;
      write_valid <= 1'b0;
    end else begin
      scl_q       <= scl;
      sda_q       <= sda;
      write_valid <= 1'b0;
      if (scl_q && scl && sda_q && !sda) begin   // Start condition
        in_frame <= 1'b1;
        bit_cnt  <= '0;
      end else if (scl_q && scl && !sda_q && sda) begin
        in_frame <= 1'b0;
        if (in_frame && bit_cnt >= 5'd27) begin
          write_valid <= 1'b1;
          addr_byte   <= shift_reg[26:19];
          reg_addr    <= shift_reg[17:10];
          reg_data    <= shift_reg[8:1];
        end
      end else if (in_frame && !scl_q && scl) begin
        if (bit_cnt < 5'd27)
          shift_reg <= {shift_reg[25:0], sda};
        bit_cnt <= bit_cnt + 5'd1;
      end else if (in_frame && scl_q && !scl) begin
        // Hold SDA low through the ack slot that follows
        sda_pull <= !nack && (bit_cnt == 5'd8 || bit_cnt == 5'd17 || bit_cnt == 5'd26);
      end
    end
  end

endmodule

/* test/tb_dvi_out.sv */
// DVI output testbench
`timescale 1ns/1ps
`include "dvi_cfg.svh"

module tb_dvi_out;

  import dvi_pkg::*;

  localparam int write_timeout = 150000;         // One configuration is about 110k cycles
  localparam int line_timeout  = 4000;
  localparam int frame_timeout = 1200000;

  logic       clk = 1'b0;
  logic       reset;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_data_t  pwdata;
  apb_data_t  prdata;
  logic       pready;
  logic       scl_low;
  logic       sda_low;
  logic       hsync;
  logic       vsync;
  logic       de;
  logic       scl_bus;
  logic       sda_bus;
  logic       sda_pull;
  logic       nack;
  logic       abort;
  logic       write_valid;
  logic [7:0] addr_byte;
  logic [7:0] reg_addr;
  logic [7:0] reg_data;

  logic [31:0] lfsr;
  logic [23:0] log_q[$];
  int          cycle_count = 0;
  int          errors;
  int          passed;
  int          failed;

  always #2 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // Wired-AND bus where only the master drives SCL
  assign scl_bus = ~scl_low;
  assign sda_bus = ~(sda_low | sda_pull);
  assign abort   = psel && penable && pwrite && (paddr == `DVI_REG_CTRL) && pwdata[1];

  dvi_out_top uut (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .scl_in  (scl_bus),
    .sda_in  (sda_bus),
    .prdata  (prdata),
    .pready  (pready),
    .scl_low (scl_low),
    .sda_low (sda_low),
    .hsync   (hsync),
    .vsync   (vsync),
    .de      (de)
  );

  tb_i2c_slave slave (
    .clk         (clk),
    .reset       (reset),
    .abort       (abort),
    .nack        (nack),
    .scl         (scl_bus),
    .sda         (sda_bus),
    .sda_pull    (sda_pull),
    .write_valid (write_valid),
    .addr_byte   (addr_byte),
    .reg_addr    (reg_addr),
    .reg_data    (reg_data)
  );

  always @(posedge clk) begin
    if (reset || abort)
      log_q.delete();                            // Only writes after the last restart count
    else if (write_valid)
      log_q.push_back({addr_byte, reg_addr, reg_data});
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Register and data byte expected for each table entry
  function automatic logic [15:0] table_entry(input int idx, input logic rate);
    case (idx)
      0:       return 16'h49C0;
      1:       return 16'h2109;
      2:       return rate ? 16'h3306 : 16'h3308;
      3:       return rate ? 16'h3426 : 16'h3416;
      default: return rate ? 16'h36A0 : 16'h3660;
    endcase
  endfunction

  task automatic bus_access(output apb_data_t data);
    int cycles;
    cycles = 0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    if (!pready) begin
      $display("timeout: APB transfer never saw pready");
      errors++;
    end
    data = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    bus_access(unused);
  endtask

  task automatic check_reg(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t got;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    bus_access(got);
    if (got !== exp) begin
      $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_writes(output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (log_q.size() < 5 && cycles < write_timeout) begin
      @(negedge clk);
      cycles++;
    end
    ok = (log_q.size() >= 5);
    if (!ok) begin
      $display("timeout: only %0d of 5 I2C writes arrived", log_q.size());
      errors++;
    end
  endtask

  task automatic check_writes(input logic rate);
    logic [23:0] entry;
    logic [15:0] exp;
    int          i;
    for (i = 0; i < log_q.size() && i < 5; i++) begin
      entry = log_q[i];
      exp   = table_entry(i, rate);
      if (entry[23:16] != 8'hEC) begin
        $display("error: addr_byte %0d got 0x%02h expected 0xec", i, entry[23:16]);
        errors++;
      end
      if (entry[15:8] != exp[15:8]) begin
        $display("error: reg_addr %0d got 0x%02h expected 0x%02h", i, entry[15:8], exp[15:8]);
        errors++;
      end
      if (entry[7:0] != exp[7:0]) begin
        $display("error: reg_data %0d got 0x%02h expected 0x%02h", i, entry[7:0], exp[7:0]);
        errors++;
      end
    end
  endtask

  task automatic wait_sync(input bit vert, input logic level, input int limit, output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (((vert ? vsync : hsync) !== level) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    ok = ((vert ? vsync : hsync) === level);
    if (!ok) begin
      $display("timeout: %s never went to %0d", vert ? "vsync" : "hsync", level);
      errors++;
    end
  endtask

  task automatic check_video(input logic m);
    int t0;
    int t1;
    int t2;
    int cycles;
    int exp_total;
    int exp_sync;
    bit ok;
    exp_total = m ? `DVI_H_TOTAL_1 : `DVI_H_TOTAL_0;
    exp_sync  = m ? `DVI_H_SYNC_1 : `DVI_H_SYNC_0;
    wait_sync(1'b0, 1'b1, line_timeout, ok);     // First pulse may straddle a mode switch
    if (ok) wait_sync(1'b0, 1'b0, line_timeout, ok);
    if (ok) wait_sync(1'b0, 1'b1, line_timeout, ok);
    t0 = cycle_count;
    if (ok) wait_sync(1'b0, 1'b0, line_timeout, ok);
    t1 = cycle_count;
    if (ok) wait_sync(1'b0, 1'b1, line_timeout, ok);
    t2 = cycle_count;
    if (ok && t2 - t0 != exp_total) begin
      $display("error: hsync period got 0x%0h expected 0x%0h", t2 - t0, exp_total);
      errors++;
    end
    if (ok && t1 - t0 != exp_sync) begin
      $display("error: hsync width got 0x%0h expected 0x%0h", t1 - t0, exp_sync);
      errors++;
    end
    if (ok) wait_sync(1'b1, 1'b1, frame_timeout, ok);
    cycles = 0;
    while (ok && vsync && cycles < 16000) begin
      if (de) begin
        $display("error: de got 0x1 expected 0x0 while vsync is high");
        errors++;
      end
      @(negedge clk);
      cycles++;
    end
    if (ok && vsync) begin
      $display("timeout: vsync stayed high too long");
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int mark);
    if (errors == mark) begin
      passed++;
      $display("test %s: pass", name);
    end else begin
      failed++;
      $display("test %s: fail with %0d errors", name, errors - mark);
    end
  endtask

  initial begin
    logic [31:0] r;
    apb_data_t   model_status;
    logic        model_mode;
    logic        start;
    bit          ok;
    int          mark;
    int          i;
    lfsr    = 32'h26e23614;
    errors  = 0;
    passed  = 0;
    failed  = 0;
    reset   <= 1'b1;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    nack    <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    mark = errors;
    wait_writes(ok);
    if (ok) check_writes(1'b0);
    check_reg(`DVI_REG_STATUS, 32'h1, "status");
    end_test("reset configuration", mark);

    mark = errors;
    write_reg(`DVI_REG_CTRL, 32'h3);
    wait_writes(ok);
    if (ok) check_writes(1'b1);
    check_reg(`DVI_REG_CTRL, 32'h1, "ctrl");
    check_reg(`DVI_REG_STATUS, 32'h1, "status");
    end_test("high rate restart", mark);

    mark = errors;
    check_video(1'b1);
    write_reg(`DVI_REG_CTRL, 32'h0);
    check_video(1'b0);
    end_test("video timing", mark);

    mark = errors;
    @(posedge clk);
    nack <= 1'b1;
    write_reg(`DVI_REG_CTRL, 32'h2);
    wait_writes(ok);
    if (ok) check_writes(1'b0);
    check_reg(`DVI_REG_STATUS, 32'h5, "status");
    @(posedge clk);
    nack <= 1'b0;
    write_reg(`DVI_REG_CTRL, 32'h2);
    wait_writes(ok);
    if (ok) check_writes(1'b0);
    check_reg(`DVI_REG_STATUS, 32'h1, "status");
    end_test("missing acknowledge", mark);

    mark         = errors;
    model_mode   = 1'b0;
    model_status = 32'h1;
    for (i = 0; i < 40; i++) begin
      take_bits(1, r);
      if (r[0]) begin
        take_bits(1, r);
        model_mode = r[0];
        take_bits(2, r);
        start = (r[1:0] == 2'b00);               // Start set one time in four
        write_reg(`DVI_REG_CTRL, {30'd0, start, model_mode});
        if (start)
          model_status = 32'h2;
      end else begin
        take_bits(1, r);
        if (r[0])
          check_reg(`DVI_REG_STATUS, model_status, "status");
        else
          check_reg(`DVI_REG_CTRL, {31'd0, model_mode}, "ctrl");
      end
      take_bits(3, r);
      repeat (r[2:0]) @(posedge clk);
    end
    take_bits(1, r);
    model_mode = r[0];
    write_reg(`DVI_REG_CTRL, {30'd0, 1'b1, model_mode});
    wait_writes(ok);
    if (ok) check_writes(model_mode);
    check_reg(`DVI_REG_STATUS, 32'h1, "status");
    check_reg(`DVI_REG_CTRL, {31'd0, model_mode}, "ctrl");
    end_test("random register traffic", mark);

    $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* dvi_out.f */
+incdir+rtl
rtl/dvi_pkg.sv
rtl/dvi_apb_regs.sv
rtl/dvi_i2c_init.sv
rtl/dvi_timing.sv
rtl/dvi_out_top.sv
test/tb_i2c_slave.sv
test/tb_dvi_out.sv

/* run_sim.sh */
#!/bin/sh
# Builds the DVI output testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_dvi_out -Mdir obj_dir -o sim_dvi_out \
  -f dvi_out.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_dvi_out > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0
